// File: Makefile
TOOL  ?= verilator
FLAGS ?= --binary --timing
TOP   ?= tb_vec_ldst
FLIST ?= vec_ldst.f
LOG   ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

// File: avalon_burst_if.sv
// Avalon-MM burst master bundle between the load/store unit and the SDRAM side
`timescale 1ns/100ps
`include "vec_ldst_config.svh"

interface avalon_burst_if import avalon_pkg::*; ();

    avm_addr_t                  address;
    logic                       read;
    logic                       write;
    avm_word_t                  writedata;
    logic [`VLDST_BUS_W/8-1:0]  byteenable;
    avm_burst_t                 burstcount;
    logic                       waitrequest;
    avm_word_t                  readdata;
    logic                       readdatavalid;

    modport master (
        output address, read, write, writedata, byteenable, burstcount,
        input  waitrequest, readdata, readdatavalid
    );

    modport slave (
        input  address, read, write, writedata, byteenable, burstcount,
        output waitrequest, readdata, readdatavalid
    );

endinterface

// File: avalon_pkg.sv
// Types of the Avalon-MM burst bus imported by files that carry addresses, beats or counts
`include "vec_ldst_config.svh"

package avalon_pkg;

    // Byte address into SDRAM
    typedef logic [`VLDST_ADDR_W-1:0] avm_addr_t;

    typedef logic [`VLDST_BUS_W-1:0] avm_word_t;

    // Must reach the full beat count of a line
    typedef logic [$clog2(`VLDST_BEATS):0] avm_burst_t;

endpackage

// File: ldst_cmd_if.sv
// Command, busy and done signals between the command issuer and the load/store unit
`timescale 1ns/100ps

interface ldst_cmd_if import avalon_pkg::*; import vldst_pkg::*; ();

    // One-cycle pulse that is dropped while busy
    logic       start;
    ldst_op_e   op;
    avm_addr_t  mem_addr;
    vrf_idx_t   rf_idx;
    line_cnt_t  line_cnt;
    logic       busy;
    logic       done;

    modport issuer (
        output start, op, mem_addr, rf_idx, line_cnt,
        input  busy, done
    );

    modport unit (
        input  start, op, mem_addr, rf_idx, line_cnt,
        output busy, done
    );

endinterface

// File: tb_vec_ldst.sv
// Testbench top for the vector load/store unit; run through the Makefile with vec_ldst.f
`timescale 1ns/100ps
`include "vec_ldst_config.svh"

module tb_vec_ldst import avalon_pkg::*; import vldst_pkg::*; ();

    logic                       clk;
    logic                       rst_n;
    logic                       cmd_start;
    ldst_op_e                   cmd_op;
    avm_addr_t                  cmd_mem_addr;
    vrf_idx_t                   cmd_rf_idx;
    line_cnt_t                  cmd_line_cnt;
    logic                       cmd_busy;
    logic                       cmd_done;
    avm_addr_t                  avm_address;
    logic                       avm_read;
    logic                       avm_write;
    avm_word_t                  avm_writedata;
    logic [`VLDST_BUS_W/8-1:0]  avm_byteenable;
    avm_burst_t                 avm_burstcount;
    logic                       avm_waitrequest;
    avm_word_t                  avm_readdata;
    logic                       avm_readdatavalid;
    logic                       exe_rd_en;
    vrf_idx_t                   exe_rd_idx;
    vrf_line_t                  exe_rd_data;

    // Slave memory and the reference images
    avm_word_t  mem [avm_addr_t];
    avm_word_t  ref_mem [avm_addr_t];
    vrf_line_t  rf_img [`VLDST_RF_DEPTH];
    logic       stalls;
    int         rd0;
    int         wr0;

    vec_ldst_top uut (.*);

    vldst_checker chk (
        .clk               (clk),
        .avm_address       (avm_address),
        .avm_read          (avm_read),
        .avm_write         (avm_write),
        .avm_writedata     (avm_writedata),
        .avm_byteenable    (avm_byteenable),
        .avm_burstcount    (avm_burstcount),
        .avm_waitrequest   (avm_waitrequest),
        .exe_rd_en         (exe_rd_en),
        .exe_rd_data       (exe_rd_data)
    );

    always #4 clk = ~clk;

    // Unwritten words read back a value built from the whole address
    function automatic avm_word_t fill_word(avm_addr_t a);
        return (a * 32'h9e37_79b9) ^ 32'h5bd1_e995;
    endfunction

    function automatic avm_word_t mem_word(avm_addr_t a);
        return mem.exists(a) ? mem[a] : fill_word(a);
    endfunction

    function automatic avm_word_t ref_word(avm_addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
    endfunction

    // Expected line for a load with beat 0 in the low bits
    function automatic vrf_line_t ref_line(avm_addr_t a);
        vrf_line_t line;
        for (int b = 0; b < `VLDST_BEATS; b++)
            line[b*`VLDST_BUS_W +: `VLDST_BUS_W] = ref_word(a + avm_addr_t'(4*b));
        return line;
    endfunction

    // Avalon slave model sampling at the falling edge and driving after the rising edge
    initial begin : slave
        int         rd_left;
        int         gap;
        int         wr_beat;
        avm_addr_t  rd_addr;
        avm_addr_t  wr_base;
        rd_left = 0;
        gap = 0;
        wr_beat = 0;
        rd_addr = '0;
        wr_base = '0;
        forever begin
            @(negedge clk);
            if (avm_write && !avm_waitrequest) begin
                if (wr_beat == 0)
                    wr_base = avm_address;
                mem[wr_base + avm_addr_t'(4*wr_beat)] = avm_writedata;
                wr_beat = (wr_beat + 1) % `VLDST_BEATS;
            end
            if (avm_read && !avm_waitrequest) begin
                rd_left = `VLDST_BEATS;
                rd_addr = avm_address;
                gap = stalls ? int'($urandom % 4) : 0;
            end
            @(posedge clk);
            #1;
            avm_waitrequest = stalls && ($urandom % 3 == 0);
            avm_readdatavalid = 1'b0;
            if (rd_left > 0) begin
                if (gap > 0) begin
                    gap--;
                end else begin
                    avm_readdatavalid = 1'b1;
                    avm_readdata = mem_word(rd_addr);
                    rd_addr += 4;
                    rd_left--;
                    gap = stalls ? int'($urandom % 4) : 0;
                end
            end
        end
    end

    task automatic expect_idle(string when);
        @(negedge clk);
        if (cmd_busy || cmd_done || avm_read || avm_write)
            chk.note_error($sformatf("ERROR busy/done/read/write %s expected 0 got %h",
                                     when, {cmd_busy, cmd_done, avm_read, avm_write}));
    endtask

    task automatic preload(avm_addr_t a, int n);
        avm_word_t w;
        for (int i = 0; i < n; i++) begin
            w = $urandom;
            mem[a + avm_addr_t'(4*i)] = w;
            ref_mem[a + avm_addr_t'(4*i)] = w;
        end
    endtask

    task automatic pulse_start(ldst_op_e op, avm_addr_t a, vrf_idx_t idx, int cnt);
        @(posedge clk);
        #1;
        cmd_start = 1'b1;
        cmd_op = op;
        cmd_mem_addr = a;
        cmd_rf_idx = idx;
        cmd_line_cnt = line_cnt_t'(cnt);
        @(posedge clk);
        #1;
        cmd_start = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        int seen;
        n = 0;
        seen = 0;
        while (seen == 0 && n < 4000) begin
            @(negedge clk);
            if (cmd_done) begin
                seen++;
                if (cmd_busy)
                    chk.note_error("ERROR cmd_busy expected 0 got 1 in the done cycle");
            end
            n++;
        end
        if (seen == 0) begin
            $display("Timeout: no done pulse within 4000 cycles");
            $display("FAIL: see errors above");
            $finish;
        end else begin
            repeat (4) begin
                @(negedge clk);
                if (cmd_done)
                    seen++;
            end
            if (seen != 1)
                chk.note_error($sformatf("done pulsed %0d times for one command", seen));
        end
    endtask

    task automatic do_load(avm_addr_t a, vrf_idx_t idx, int cnt);
        pulse_start(LDST_LOAD, a, idx, cnt);
        wait_done();
        for (int i = 0; i < cnt; i++)
            rf_img[vrf_idx_t'(idx + i)] = ref_line(a + avm_addr_t'(16*i));
    endtask

    task automatic do_store(avm_addr_t a, vrf_idx_t idx, int cnt);
        avm_addr_t wa;
        avm_word_t wd;
        for (int i = 0; i < cnt; i++) begin
            for (int b = 0; b < `VLDST_BEATS; b++) begin
                wa = a + avm_addr_t'(16*i);
                wd = rf_img[vrf_idx_t'(idx + i)][b*`VLDST_BUS_W +: `VLDST_BUS_W];
                chk.expect_beat(wa, wd);
                ref_mem[wa + avm_addr_t'(4*b)] = wd;
            end
        end
        pulse_start(LDST_STORE, a, idx, cnt);
        wait_done();
    endtask

    task automatic read_line(vrf_idx_t idx);
        @(posedge clk);
        #1;
        exe_rd_en = 1'b1;
        exe_rd_idx = idx;
        chk.expect_line(rf_img[idx]);
        @(posedge clk);
        #1;
        exe_rd_en = 1'b0;
        @(negedge clk);
    endtask

    // Compares memory words at a with the reference words at ref_a
    task automatic check_mem(avm_addr_t a, avm_addr_t ref_a, int n);
        for (int i = 0; i < n; i++)
            if (mem_word(a + avm_addr_t'(4*i)) !== ref_word(ref_a + avm_addr_t'(4*i)))
                chk.note_error($sformatf("ERROR mem[%h] expected %h got %h",
                               a + avm_addr_t'(4*i), ref_word(ref_a + avm_addr_t'(4*i)),
                               mem_word(a + avm_addr_t'(4*i))));
    endtask

    initial begin
        void'($urandom(32'hfc35));
        clk = 1'b0;
        rst_n = 1'b0;
        cmd_start = 1'b0;
        cmd_op = LDST_LOAD;
        cmd_mem_addr = '0;
        cmd_rf_idx = '0;
        cmd_line_cnt = '0;
        avm_waitrequest = 1'b0;
        avm_readdata = '0;
        avm_readdatavalid = 1'b0;
        exe_rd_en = 1'b0;
        exe_rd_idx = '0;
        stalls = 1'b0;

        expect_idle("in reset");
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        expect_idle("after reset");
        chk.finish_test("reset state");

        preload(32'h1000, 4);
        do_load(32'h1000, 4'd3, 1);
        read_line(4'd3);
        chk.finish_test("single-line load");

        stalls = 1'b1;
        preload(32'h2000, 64);
        do_load(32'h2000, 4'd9, 16);
        for (int i = 0; i < 16; i++)
            read_line(vrf_idx_t'(9 + i));
        chk.finish_test("16-line wrapping load");

        do_store(32'h8000, 4'd9, 3);
        check_mem(32'h8000, 32'h8000, 12);
        chk.finish_test("3-line store");

        preload(32'h3000, 16);
        do_load(32'h3000, 4'd2, 4);
        do_store(32'h9000, 4'd2, 4);
        check_mem(32'h9000, 32'h3000, 16);
        rd0 = chk.rd_cmds;
        wr0 = chk.wr_beats;
        pulse_start(LDST_LOAD, 32'h4000, 4'd0, 0);
        wait_done();
        if (chk.rd_cmds != rd0 || chk.wr_beats != wr0)
            chk.note_error("zero-line command caused bus activity");
        chk.finish_test("copy and zero count");

        preload(32'h5000, 8);
        pulse_start(LDST_LOAD, 32'h5000, 4'd12, 2);
        pulse_start(LDST_STORE, 32'ha000, 4'd12, 2);
        wait_done();
        rf_img[12] = ref_line(32'h5000);
        rf_img[13] = ref_line(32'h5010);
        check_mem(32'ha000, 32'ha000, 8);
        read_line(4'd13);
        chk.finish_test("start while busy");

        chk.close();
        if (chk.err_cnt == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: vec_ldst.f
+incdir+.
avalon_pkg.sv
vldst_pkg.sv
avalon_burst_if.sv
vrf_port_if.sv
ldst_cmd_if.sv
vrf_bram.sv
vec_ldst_unit.sv
vec_ldst_top.sv
vldst_checker.sv
tb_vec_ldst.sv

// File: vec_ldst_config.svh
// Sizes of the bus, register-file lines and addresses for every design and test file
`ifndef VEC_LDST_CONFIG_SVH
`define VEC_LDST_CONFIG_SVH

// One Avalon data beat
`define VLDST_BUS_W 32

// One register-file line
`define VLDST_LINE_W 128

// Beats in one line burst
`define VLDST_BEATS (`VLDST_LINE_W / `VLDST_BUS_W)

`define VLDST_RF_DEPTH 16

// SDRAM byte address
`define VLDST_ADDR_W 32

`endif

// File: vec_ldst_top.sv
// Top level of the vector load/store unit and its register file with plain ports
`timescale 1ns/100ps
`default_nettype none
`include "vec_ldst_config.svh"

module vec_ldst_top
    import avalon_pkg::*;
    import vldst_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       cmd_start,
    input  ldst_op_e                   cmd_op,
    input  avm_addr_t                  cmd_mem_addr,
    input  vrf_idx_t                   cmd_rf_idx,
    input  line_cnt_t                  cmd_line_cnt,
    output logic                       cmd_busy,
    output logic                       cmd_done,

    output avm_addr_t                  avm_address,
    output logic                       avm_read,
    output logic                       avm_write,
    output avm_word_t                  avm_writedata,
    output logic [`VLDST_BUS_W/8-1:0]  avm_byteenable,
    output avm_burst_t                 avm_burstcount,
    input  logic                       avm_waitrequest,
    input  avm_word_t                  avm_readdata,
    input  logic                       avm_readdatavalid,

    input  logic                       exe_rd_en,
    input  vrf_idx_t                   exe_rd_idx,
    output vrf_line_t                  exe_rd_data
);

    ldst_cmd_if     cmd_bus ();
    avalon_burst_if avm_bus ();
    vrf_port_if     rf_bus ();

    assign cmd_bus.start    = cmd_start;
    assign cmd_bus.op       = cmd_op;
    assign cmd_bus.mem_addr = cmd_mem_addr;
    assign cmd_bus.rf_idx   = cmd_rf_idx;
    assign cmd_bus.line_cnt = cmd_line_cnt;
    assign cmd_busy         = cmd_bus.busy;
    assign cmd_done         = cmd_bus.done;

    assign avm_address    = avm_bus.address;
    assign avm_read       = avm_bus.read;
    assign avm_write      = avm_bus.write;
    assign avm_writedata  = avm_bus.writedata;
    assign avm_byteenable = avm_bus.byteenable;
    assign avm_burstcount = avm_bus.burstcount;

    assign avm_bus.waitrequest   = avm_waitrequest;
    assign avm_bus.readdata      = avm_readdata;
    assign avm_bus.readdatavalid = avm_readdatavalid;

    vec_ldst_unit u_unit (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd_bus.unit),
        .avm   (avm_bus.master),
        .rf    (rf_bus.unit)
    );

    vrf_bram u_vrf (
        .clk         (clk),
        .rf          (rf_bus.ram),
        .exe_rd_en   (exe_rd_en),
        .exe_rd_idx  (exe_rd_idx),
        .exe_rd_data (exe_rd_data)
    );

endmodule

`default_nettype wire

// File: vec_ldst_unit.sv
// Vector load/store engine moving register-file lines to and from SDRAM as Avalon bursts
`timescale 1ns/100ps
`default_nettype none
`include "vec_ldst_config.svh"

module vec_ldst_unit
    import avalon_pkg::*;
    import vldst_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    ldst_cmd_if.unit        cmd,
    avalon_burst_if.master  avm,
    vrf_port_if.unit        rf
);

    localparam int BEAT_W = $clog2(`VLDST_BEATS);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`VLDST_BEATS - 1);
    // Bytes per line
    localparam avm_addr_t STRIDE = avm_addr_t'(`VLDST_LINE_W / 8);

    ldst_state_e        state, state_nxt;
    avm_addr_t          mem_addr_q;
    vrf_idx_t           idx_q;
    line_cnt_t          remain_q;
    logic [BEAT_W-1:0]  beat_q;
    vrf_line_t          line_buf;

    logic accept;
    logic beat_step;
    logic line_done;
    logic last_line;

    assign accept    = cmd.start && (state == IDLE || state == FINISH);
    assign beat_step = (state == RD_BEATS && avm.readdatavalid) ||
                       (state == WR_BEATS && !avm.waitrequest);
    assign line_done = (state == RF_WRITE) ||
                       (state == WR_BEATS && !avm.waitrequest && beat_q == LAST_BEAT);
    assign last_line = (remain_q == line_cnt_t'(1));

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE, FINISH: begin
                if (!accept)
                    state_nxt = IDLE;
                else if (cmd.line_cnt == '0)
                    state_nxt = FINISH;
                else if (cmd.op == LDST_LOAD)
                    state_nxt = RD_REQ;
                else
                    state_nxt = RF_READ;
            end
            RD_REQ: begin
                if (!avm.waitrequest)
                    state_nxt = RD_BEATS;
            end
            RD_BEATS: begin
                if (avm.readdatavalid && beat_q == LAST_BEAT)
                    state_nxt = RF_WRITE;
            end
            RF_WRITE:
                state_nxt = last_line ? FINISH : RD_REQ;
            RF_READ:
                state_nxt = WR_BEATS;
            WR_BEATS: begin
                if (line_done)
                    state_nxt = last_line ? FINISH : RF_READ;
            end
            default:
                state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            mem_addr_q <= '0;
            idx_q      <= '0;
            remain_q   <= '0;
            beat_q     <= '0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                mem_addr_q <= cmd.mem_addr;
                idx_q      <= cmd.rf_idx;
                remain_q   <= cmd.line_cnt;
                beat_q     <= '0;
            end else begin
                if (beat_step)
                    beat_q <= beat_q + 1'b1;
                // Index wraps around the register file
                if (line_done) begin
                    mem_addr_q <= mem_addr_q + STRIDE;
                    idx_q      <= idx_q + 1'b1;
                    remain_q   <= remain_q - 1'b1;
                end
            end
        end
    end

    // Beat 0 sits in the low bits
    always_ff @(posedge clk) begin
        if (state == RD_BEATS && avm.readdatavalid)
            line_buf[beat_q*`VLDST_BUS_W +: `VLDST_BUS_W] <= avm.readdata;
        else if (state == RF_READ)
            line_buf <= rf.rdata;
    end

    // RAM read is issued one cycle ahead so rdata is ready in RF_READ
    assign rf.re    = (state_nxt == RF_READ);
    assign rf.we    = (state == RF_WRITE);
    assign rf.wdata = line_buf;

    always_comb begin
        if (accept)
            rf.idx = cmd.rf_idx;
        else if (state == WR_BEATS)
            rf.idx = idx_q + 1'b1;
        else
            rf.idx = idx_q;
    end

    assign avm.address    = mem_addr_q;
    assign avm.read       = (state == RD_REQ);
    assign avm.write      = (state == WR_BEATS);
    assign avm.writedata  = line_buf[beat_q*`VLDST_BUS_W +: `VLDST_BUS_W];
    assign avm.byteenable = '1;
    assign avm.burstcount = avm_burst_t'(`VLDST_BEATS);

    assign cmd.busy = (state != IDLE) && (state != FINISH);
    assign cmd.done = (state == FINISH);

endmodule

`default_nettype wire

// File: vldst_checker.sv
// Testbench checker comparing write beats and execution-port lines with the expected queues
`timescale 1ns/100ps
`include "vec_ldst_config.svh"

module vldst_checker import avalon_pkg::*; import vldst_pkg::*; (
    input  logic                       clk,
    input  avm_addr_t                  avm_address,
    input  logic                       avm_read,
    input  logic                       avm_write,
    input  avm_word_t                  avm_writedata,
    input  logic [`VLDST_BUS_W/8-1:0]  avm_byteenable,
    input  avm_burst_t                 avm_burstcount,
    input  logic                       avm_waitrequest,
    input  logic                       exe_rd_en,
    input  vrf_line_t                  exe_rd_data
);

    avm_addr_t  exp_addr [$];
    avm_word_t  exp_data [$];
    vrf_line_t  exp_line [$];
    vrf_line_t  line_exp;
    int         err_cnt = 0;
    int         test_base = 0;
    int         tests = 0;
    int         failed = 0;
    int         rd_cmds = 0;
    int         wr_beats = 0;
    logic       rd_pend = 1'b0;

    task automatic note_error(string msg);
        $display("%s", msg);
        err_cnt++;
    endtask

    task automatic expect_beat(avm_addr_t a, avm_word_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    task automatic expect_line(vrf_line_t l);
        exp_line.push_back(l);
    endtask

    always @(negedge clk) begin
        if (avm_read && !avm_waitrequest)
            rd_cmds++;
        if (avm_write && !avm_waitrequest) begin
            wr_beats++;
            if (exp_addr.size() == 0) begin
                note_error($sformatf("write beat at %h with none expected", avm_address));
            end else begin
                if (avm_address !== exp_addr[0])
                    note_error($sformatf("ERROR avm_address expected %h got %h",
                                         exp_addr[0], avm_address));
                if (avm_writedata !== exp_data[0])
                    note_error($sformatf("ERROR avm_writedata expected %h got %h",
                                         exp_data[0], avm_writedata));
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
            if (avm_burstcount !== avm_burst_t'(`VLDST_BEATS))
                note_error($sformatf("ERROR avm_burstcount expected %h got %h",
                                     `VLDST_BEATS, avm_burstcount));
            if (avm_byteenable !== '1)
                note_error($sformatf("ERROR avm_byteenable expected f got %h", avm_byteenable));
        end
        // Line is on exe_rd_data one clock after the enable
        if (rd_pend) begin
            if (exp_line.size() == 0) begin
                note_error("execution-port read with no expected line");
            end else begin
                line_exp = exp_line.pop_front();
                if (exe_rd_data !== line_exp)
                    note_error($sformatf("ERROR exe_rd_data expected %h got %h",
                                         line_exp, exe_rd_data));
            end
        end
        rd_pend = exe_rd_en;
    end

    task automatic finish_test(string name);
        if (exp_addr.size() != 0)
            note_error($sformatf("%0d expected write beats never appeared", exp_addr.size()));
        exp_addr.delete();
        exp_data.delete();
        tests++;
        if (err_cnt != test_base) begin
            failed++;
            $display("test %s: failed with %0d errors", name, err_cnt - test_base);
        end else begin
            $display("test %s: ok", name);
        end
        test_base = err_cnt;
    endtask

    task automatic close();
        $display("tests %0d, failed %0d, errors %0d", tests, failed, err_cnt);
    endtask

endmodule

// File: vldst_pkg.sv
// Types of the load/store engine and its register file imported by the design modules
`include "vec_ldst_config.svh"

package vldst_pkg;

    typedef enum logic {
        LDST_LOAD  = 1'b0,
        LDST_STORE = 1'b1
    } ldst_op_e;

    typedef enum logic [2:0] {
        IDLE,
        RD_REQ,
        RD_BEATS,
        RF_WRITE,
        RF_READ,
        WR_BEATS,
        FINISH
    } ldst_state_e;

    typedef logic [`VLDST_LINE_W-1:0] vrf_line_t;
    typedef logic [$clog2(`VLDST_RF_DEPTH)-1:0] vrf_idx_t;

    // One extra bit so a full register file fits
    typedef logic [$clog2(`VLDST_RF_DEPTH):0] line_cnt_t;

endpackage

// File: vrf_bram.sv
// Dual-port vector register file with port A for the load/store unit and read-only port B
`timescale 1ns/100ps
`default_nettype none
`include "vec_ldst_config.svh"

module vrf_bram
    import vldst_pkg::*;
(
    input  logic        clk,

    vrf_port_if.ram     rf,

    // Execution side
    input  logic        exe_rd_en,
    input  vrf_idx_t    exe_rd_idx,
    output vrf_line_t   exe_rd_data
);

    vrf_line_t mem [`VLDST_RF_DEPTH];

    // Port A write and registered read
    always_ff @(posedge clk) begin
        if (rf.we)
            mem[rf.idx] <= rf.wdata;
        if (rf.re)
            rf.rdata <= mem[rf.idx];
    end

    // Port B
    always_ff @(posedge clk) begin
        if (exe_rd_en)
            exe_rd_data <= mem[exe_rd_idx];
    end

endmodule

`default_nettype wire

// File: vrf_port_if.sv
// Register-file port A owned by the load/store unit and served by the block RAM
`timescale 1ns/100ps

interface vrf_port_if import vldst_pkg::*; ();

    vrf_idx_t   idx;
    logic       we;
    vrf_line_t  wdata;
    logic       re;
    // Valid one clock after re
    vrf_line_t  rdata;

    modport unit (
        output idx, we, wdata, re,
        input  rdata
    );

    modport ram (
        input  idx, we, wdata, re,
        output rdata
    );

endinterface
